//--- caddr_io.f
caddr_io_pkg.sv
spy_uart_rx.sv
ps2_kbd_rx.sv
spy_bridge.sv
io_regs.sv
spy_uart_tx.sv
caddr_io_top.sv
tb_clk_gen.sv
tb_caddr_io.sv

//--- Makefile
# Verilator build and run of the caddr_io testbench

VERILATOR ?= verilator
TOP       ?= tb_caddr_io
FLIST     ?= caddr_io.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

.PHONY: sim clean

# the run itself may end with any status, the log decides
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_caddr_io.sv
`timescale 1ns/10ps

module tb_caddr_io;

   import caddr_io_pkg::*;

   localparam int CLKS_PER_BIT  = 16;
   localparam int KB_FIFO_DEPTH = 4;
   localparam int PS2_HALF      = 12;     // clk50 cycles per ps2 clock phase
   localparam int RX_TIMEOUT    = 4000;
   localparam int DRIVE_DLY     = 2;
   localparam logic [15:0] ID_EXPECT    = 16'hCAD2;
   localparam logic [3:0]  UNMAPPED_ADR = 4'hC;   // low three bits alias REG_SCRATCH

   logic        clk50;
   logic        rst_n;
   logic        usb_rxd;
   logic        ps2_clk;
   logic        ps2_data;
   logic        usb_txd;
   logic [3:0]  led;
   integer      seed;
   int          error_count;
   int          tests_run;
   int          tests_failed;
   logic [3:0]  led_shadow;       // last values written by the tests
   logic [15:0] scratch_shadow;

   tb_clk_gen #(.PERIOD_NS(40), .RESET_CYCLES(16)) u_clk_gen (.clk50(clk50), .rst_n(rst_n));

   caddr_io_top #(
      .CLKS_PER_BIT  (CLKS_PER_BIT),
      .KB_FIFO_DEPTH (KB_FIFO_DEPTH)
   ) UUT (
      .clk50    (clk50),
      .rst_n    (rst_n),
      .usb_rxd  (usb_rxd),
      .ps2_clk  (ps2_clk),
      .ps2_data (ps2_data),
      .usb_txd  (usb_txd),
      .led      (led)
   );

   // leaves the caller just after a rising edge, where inputs change
   task automatic step_clocks(input int n);
      repeat (n) @(posedge clk50);
      #DRIVE_DLY;
   endtask

   task automatic send_serial(input logic [7:0] b);
      logic [9:0] frame;
      int         i;
      frame = {1'b1, b, 1'b0};   // stop, data, start
      for (i = 0; i < 10; i++)
      begin
         usb_rxd = frame[i];
         step_clocks(CLKS_PER_BIT);
      end
   endtask

   // samples on the falling edge, away from the txd updates
   task automatic recv_serial(output logic [7:0] b, output logic ok);
      int n;
      int i;
      b  = 8'd0;
      ok = 1'b0;
      n  = 0;
      @(negedge clk50);
      while (usb_txd !== 1'b0 && n < RX_TIMEOUT)
      begin
         @(negedge clk50);
         n++;
      end
      if (usb_txd !== 1'b0)
      begin
         $display("timeout: no start bit on usb_txd within %0d clocks", RX_TIMEOUT);
         error_count++;
      end
      else
      begin
         repeat (CLKS_PER_BIT / 2) @(negedge clk50);   // mid start bit
         for (i = 0; i < 8; i++)
         begin
            repeat (CLKS_PER_BIT) @(negedge clk50);
            b[i] = usb_txd;
         end
         repeat (CLKS_PER_BIT) @(negedge clk50);
         if (usb_txd !== 1'b1)
         begin
            $display("reply byte had a low stop bit at %0t ns", $time);
            error_count++;
         end
         else
            ok = 1'b1;
      end
   endtask

   // the reply may start before the command's stop bit has ended
   task automatic read_reg(input logic [3:0] adr, output logic [15:0] data);
      logic [7:0] hi;
      logic [7:0] lo;
      logic       ok_hi;
      logic       ok_lo;
      lo    = 8'd0;
      ok_lo = 1'b0;
      fork
         send_serial({4'h0, adr});
         begin
            recv_serial(hi, ok_hi);
            if (ok_hi)
               recv_serial(lo, ok_lo);
         end
      join
      data = {hi, lo};
      step_clocks(CLKS_PER_BIT);
   endtask

   task automatic write_reg(input logic [3:0] adr, input logic [15:0] data);
      send_serial({1'b1, 3'b000, adr});   // bit 7 marks a write
      send_serial(data[15:8]);
      send_serial(data[7:0]);
      step_clocks(CLKS_PER_BIT);
   endtask

   task automatic send_key_frame(input logic [7:0] code, input logic bad_parity);
      logic [10:0] frame;
      int          i;
      frame = {1'b1, (~(^code)) ^ bad_parity, code, 1'b0};
      for (i = 0; i < 11; i++)
      begin
         ps2_data = frame[i];
         step_clocks(PS2_HALF);
         ps2_clk = 1'b0;   // receiver samples here
         step_clocks(PS2_HALF);
         ps2_clk = 1'b1;
      end
      ps2_data = 1'b1;
      step_clocks(PS2_HALF);
   endtask

   task automatic check_word(input string what, input logic [15:0] got,
                             input logic [15:0] exp);
      if (got !== exp)
      begin
         $display("[ERROR] %0t ns: %s read 0x%04h, expected 0x%04h", $time, what, got, exp);
         error_count++;
      end
   endtask

   task automatic wait_led(input logic [3:0] exp);
      int n;
      n = 0;
      while (led !== exp && n < 50)
      begin
         @(negedge clk50);
         n++;
      end
      if (led !== exp)
      begin
         $display("[ERROR] %0t ns: led shows %h, expected %h", $time, led, exp);
         error_count++;
      end
      step_clocks(1);
   endtask

   // overflow in bit 15, parity error in bit 14, fill count in the low nibble
   function automatic logic [15:0] kb_status_word(input logic ovf, input logic perr,
                                                  input int count);
      logic [15:0] s;
      s      = 16'd0;
      s[15]  = ovf;
      s[14]  = perr;
      s[3:0] = 4'(count);
      return s;
   endfunction

   task automatic end_test(input string name, input int errs_at_start);
      tests_run++;
      if (error_count == errs_at_start)
         $display("%s: pass", name);
      else
      begin
         tests_failed++;
         $display("%s: FAIL with %0d errors", name, error_count - errs_at_start);
      end
   endtask

   task automatic read_id();
      int          errs;
      logic [15:0] d;
      errs = error_count;
      read_reg(REG_ID, d);
      check_word("REG_ID", d, ID_EXPECT);
      end_test("read_id", errs);
   endtask

   task automatic scratch_and_led();
      int          errs;
      int          i;
      logic [15:0] v;
      logic [15:0] d;
      errs = error_count;
      v    = 16'd0;
      for (i = 0; i < 4; i++)
      begin
         v = 16'($random(seed));
         write_reg(REG_SCRATCH, v);
         read_reg(REG_SCRATCH, d);
         check_word("REG_SCRATCH", d, v);
      end
      scratch_shadow = v;
      v = 16'($random(seed));
      if (v[3:0] == 4'd0)
         v[3:0] = 4'ha;   // keep the pattern visible on led
      write_reg(REG_LED, v);
      wait_led(v[3:0]);
      read_reg(REG_LED, d);
      check_word("REG_LED", d, {12'd0, v[3:0]});
      led_shadow = v[3:0];
      end_test("scratch_and_led", errs);
   endtask

   // sends n good frames and reads back the first depth codes in order
   task automatic kbd_frames(input string name, input int n);
      int          errs;
      int          i;
      int          kept;
      logic [7:0]  codes [16];
      logic [15:0] d;
      errs = error_count;
      kept = (n > KB_FIFO_DEPTH) ? KB_FIFO_DEPTH : n;
      for (i = 0; i < n; i++)
      begin
         codes[i] = 8'($random(seed));
         send_key_frame(codes[i], 1'b0);
      end
      read_reg(REG_KB_STAT, d);
      check_word("REG_KB_STAT", d, kb_status_word(n > KB_FIFO_DEPTH, 1'b0, kept));
      for (i = 0; i < kept; i++)
      begin
         read_reg(REG_KB_DATA, d);
         check_word("REG_KB_DATA", d, {8'd0, codes[i]});
      end
      read_reg(REG_KB_DATA, d);
      check_word("REG_KB_DATA when empty", d, 16'd0);
      read_reg(REG_KB_STAT, d);
      check_word("REG_KB_STAT after drain", d, kb_status_word(1'b0, 1'b0, 0));
      end_test(name, errs);
   endtask

   task automatic kbd_parity_error();
      int          errs;
      logic [15:0] d;
      errs = error_count;
      send_key_frame(8'($random(seed)), 1'b1);
      read_reg(REG_KB_STAT, d);
      check_word("REG_KB_STAT", d, kb_status_word(1'b0, 1'b1, 0));
      read_reg(REG_KB_STAT, d);   // sticky bit cleared by the first read
      check_word("REG_KB_STAT second read", d, kb_status_word(1'b0, 1'b0, 0));
      end_test("kbd_parity_error", errs);
   endtask

   task automatic unmapped_writes();
      int          errs;
      logic [15:0] d;
      errs = error_count;
      write_reg(UNMAPPED_ADR, 16'($random(seed)));
      write_reg(REG_ID, 16'($random(seed)));
      read_reg(UNMAPPED_ADR, d);
      check_word("unmapped address", d, 16'd0);
      read_reg(REG_ID, d);
      check_word("REG_ID after write", d, ID_EXPECT);
      read_reg(REG_SCRATCH, d);
      check_word("REG_SCRATCH untouched", d, scratch_shadow);
      read_reg(REG_LED, d);
      check_word("REG_LED untouched", d, {12'd0, led_shadow});
      end_test("unmapped_writes", errs);
   endtask

   initial
   begin
      int n;
      usb_rxd        = 1'b1;
      ps2_clk        = 1'b1;
      ps2_data       = 1'b1;
      seed           = 32'hebee;
      error_count    = 0;
      tests_run      = 0;
      tests_failed   = 0;
      led_shadow     = 4'd0;
      scratch_shadow = 16'd0;
      n              = 0;
      while (rst_n !== 1'b1 && n < 100)
      begin
         @(posedge clk50);
         n++;
      end
      if (rst_n !== 1'b1)
      begin
         $display("timeout: reset was never released");
         error_count++;
      end
      step_clocks(4);
      if (usb_txd !== 1'b1 || led !== 4'd0)
      begin
         $display("[ERROR] %0t ns: after reset usb_txd=%b led=%h", $time, usb_txd, led);
         error_count++;
      end
      read_id();
      scratch_and_led();
      kbd_frames("kbd_fifo_order", 3);
      kbd_parity_error();
      kbd_frames("kbd_overflow", KB_FIFO_DEPTH + 1);
      unmapped_writes();
      $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_count);
      if (error_count == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 16
) (
   output logic clk50,
   output logic rst_n
);

   initial
   begin
      clk50 = 1'b0;
      forever #(PERIOD_NS / 2) clk50 = ~clk50;
   end

   initial
   begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk50);
      #2 rst_n = 1'b1;   // released just after an edge like every other input
   end

endmodule

//--- caddr_io_top.sv
`timescale 1ns/10ps

module caddr_io_top #(
   parameter int CLKS_PER_BIT  = 16,
   parameter int KB_FIFO_DEPTH = 4
) (
   input  logic       clk50,
   input  logic       rst_n,
   input  logic       usb_rxd,
   input  logic       ps2_clk,
   input  logic       ps2_data,
   output logic       usb_txd,
   output logic [3:0] led
);

   import caddr_io_pkg::*;

   byte_evt_t rx_byte;
   byte_evt_t tx_byte;
   wb_req_t   wb_req;
   wb_rsp_t   wb_rsp;
   kb_evt_t   kb_evt;
   logic      tx_busy;

   spy_uart_rx #(
      .CLKS_PER_BIT(CLKS_PER_BIT)
   ) u_uart_rx (
      .clk50   (clk50),
      .rst_n   (rst_n),
      .rxd     (usb_rxd),
      .rx_byte (rx_byte)
   );

   ps2_kbd_rx u_kbd_rx (
      .clk50    (clk50),
      .rst_n    (rst_n),
      .ps2_clk  (ps2_clk),
      .ps2_data (ps2_data),
      .kb_evt   (kb_evt)
   );

   spy_bridge u_bridge (
      .clk50   (clk50),
      .rst_n   (rst_n),
      .rx_byte (rx_byte),
      .wb_req  (wb_req),
      .wb_rsp  (wb_rsp),
      .tx_byte (tx_byte),
      .tx_busy (tx_busy)
   );

   io_regs #(
      .KB_FIFO_DEPTH(KB_FIFO_DEPTH)
   ) u_regs (
      .clk50  (clk50),
      .rst_n  (rst_n),
      .wb_req (wb_req),
      .wb_rsp (wb_rsp),
      .kb_evt (kb_evt),
      .led    (led)
   );

   spy_uart_tx #(
      .CLKS_PER_BIT(CLKS_PER_BIT)
   ) u_uart_tx (
      .clk50   (clk50),
      .rst_n   (rst_n),
      .tx_byte (tx_byte),
      .tx_busy (tx_busy),
      .txd     (usb_txd)
   );

endmodule

//--- spy_uart_tx.sv
`timescale 1ns/10ps

module spy_uart_tx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic                    clk50,
   input  logic                    rst_n,
   input  caddr_io_pkg::byte_evt_t tx_byte,
   output logic                    tx_busy,
   output logic                    txd
);

   localparam int CW = $clog2(CLKS_PER_BIT + 1);

   logic [CW-1:0] clk_cnt;
   logic [3:0]    bits_left;   // data bits plus stop still to go
   logic [8:0]    shift;       // stop bit sits in the msb
   logic          load;
   logic          bit_end;

   assign load    = tx_byte.valid && !tx_busy;
   assign bit_end = (clk_cnt == CW'(CLKS_PER_BIT - 1));

   always_ff @(posedge clk50)
   begin
      if (!rst_n)
      begin
         tx_busy   <= 1'b0;
         txd       <= 1'b1;
         clk_cnt   <= '0;
         bits_left <= '0;
      end
      else if (load)
      begin
         tx_busy   <= 1'b1;
         txd       <= 1'b0;   // start bit
         clk_cnt   <= '0;
         bits_left <= 4'd9;
      end
      else if (tx_busy)
      begin
         clk_cnt <= clk_cnt + 1'b1;
         if (bit_end)
         begin
            clk_cnt <= '0;
            if (bits_left == 4'd0)
               tx_busy <= 1'b0;   // stop bit done
            else
            begin
               txd       <= shift[0];
               bits_left <= bits_left - 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk50)
   begin
      if (load)
         shift <= {1'b1, tx_byte.data};
      else if (tx_busy && bit_end)
         shift <= {1'b1, shift[8:1]};
   end

endmodule

//--- io_regs.sv
`timescale 1ns/10ps

module io_regs #(
   parameter int KB_FIFO_DEPTH = 4
) (
   input  logic                  clk50,
   input  logic                  rst_n,
   input  caddr_io_pkg::wb_req_t wb_req,
   output caddr_io_pkg::wb_rsp_t wb_rsp,
   input  caddr_io_pkg::kb_evt_t kb_evt,
   output logic [3:0]            led
);

   import caddr_io_pkg::*;

   localparam int PW = (KB_FIFO_DEPTH > 1) ? $clog2(KB_FIFO_DEPTH) : 1;

   logic          ack_q;
   logic [15:0]   rdata_q;
   logic [15:0]   rd_mux;
   logic [3:0]    led_q;
   logic [15:0]   scratch_q;
   logic [7:0]    fifo_mem [KB_FIFO_DEPTH];
   logic [PW-1:0] wr_ptr;
   logic [PW-1:0] rd_ptr;
   logic [3:0]    fill;
   logic          kb_ovf;
   logic          kb_perr;
   logic          access;
   logic          wr_acc;
   logic          rd_acc;
   logic          fifo_full;
   logic          push;
   logic          pop;
   logic          stat_rd;

   function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
      if (ptr == PW'(KB_FIFO_DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign access    = wb_req.cyc && wb_req.stb && !ack_q;   // once per bus cycle
   assign wr_acc    = access && wb_req.we;
   assign rd_acc    = access && !wb_req.we;
   assign fifo_full = (fill == 4'(KB_FIFO_DEPTH));
   assign push      = kb_evt.valid && !kb_evt.err && !fifo_full;
   assign pop       = rd_acc && (wb_req.adr == REG_KB_DATA) && (fill != 4'd0);
   assign stat_rd   = rd_acc && (wb_req.adr == REG_KB_STAT);

   always_comb
   begin
      rd_mux = '0;
      case (wb_req.adr)
         REG_ID:      rd_mux = ID_VALUE;
         REG_LED:     rd_mux = {12'd0, led_q};
         REG_KB_STAT:
         begin
            rd_mux[KB_OVF_BIT]  = kb_ovf;
            rd_mux[KB_PERR_BIT] = kb_perr;
            rd_mux[3:0]         = fill;
         end
         REG_KB_DATA:
            if (fill != 4'd0)
               rd_mux = {8'd0, fifo_mem[rd_ptr]};
         REG_SCRATCH: rd_mux = scratch_q;
         default:     rd_mux = '0;   // unmapped
      endcase
   end

   always_ff @(posedge clk50)
   begin
      if (!rst_n)
      begin
         ack_q   <= 1'b0;
         led_q   <= '0;
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         fill    <= '0;
         kb_ovf  <= 1'b0;
         kb_perr <= 1'b0;
      end
      else
      begin
         ack_q <= access;
         if (wr_acc && wb_req.adr == REG_LED)
            led_q <= wb_req.dat[3:0];
         if (push)
            wr_ptr <= next_ptr(wr_ptr);
         if (pop)
            rd_ptr <= next_ptr(rd_ptr);
         fill <= fill + {3'd0, push} - {3'd0, pop};
         // sticky bits, a new event wins over the clearing read
         kb_ovf  <= (kb_ovf && !stat_rd) || (kb_evt.valid && !kb_evt.err && fifo_full);
         kb_perr <= (kb_perr && !stat_rd) || (kb_evt.valid && kb_evt.err);
      end
   end

   always_ff @(posedge clk50)
   begin
      if (access)
         rdata_q <= rd_mux;
      if (wr_acc && wb_req.adr == REG_SCRATCH)
         scratch_q <= wb_req.dat;
      if (push)
         fifo_mem[wr_ptr] <= kb_evt.code;
   end

   assign wb_rsp = '{ack: ack_q, dat: rdata_q};
   assign led    = led_q;

endmodule

//--- spy_bridge.sv
`timescale 1ns/10ps

module spy_bridge (
   input  logic                    clk50,
   input  logic                    rst_n,
   input  caddr_io_pkg::byte_evt_t rx_byte,
   output caddr_io_pkg::wb_req_t   wb_req,
   input  caddr_io_pkg::wb_rsp_t   wb_rsp,
   output caddr_io_pkg::byte_evt_t tx_byte,
   input  logic                    tx_busy
);

   import caddr_io_pkg::*;

   typedef enum logic [2:0] {
      BR_CMD,
      BR_DAT_HI,
      BR_DAT_LO,
      BR_BUS,
      BR_TX_HI,
      BR_TX_GAP,
      BR_TX_LO
   } br_state_t;

   br_state_t   state;
   logic [3:0]  cmd_adr;
   logic [7:0]  dat_hi;
   logic [15:0] rd_data;

   // rx bytes are only taken in the first three states, all others drop them
   always_ff @(posedge clk50)
   begin
      if (!rst_n)
      begin
         state   <= BR_CMD;
         wb_req  <= '0;
         tx_byte <= '0;
      end
      else
      begin
         tx_byte.valid <= 1'b0;
         case (state)
            BR_CMD:
               if (rx_byte.valid)
               begin
                  if (rx_byte.data[SPY_WR_BIT])
                     state <= BR_DAT_HI;
                  else
                  begin
                     wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0,
                                 adr: rx_byte.data[3:0], dat: 16'd0};
                     state  <= BR_BUS;
                  end
               end
            BR_DAT_HI:
               if (rx_byte.valid)
                  state <= BR_DAT_LO;
            BR_DAT_LO:
               if (rx_byte.valid)
               begin
                  wb_req <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1,
                              adr: cmd_adr, dat: {dat_hi, rx_byte.data}};
                  state  <= BR_BUS;
               end
            BR_BUS:
               if (wb_rsp.ack)
               begin
                  wb_req.cyc <= 1'b0;
                  wb_req.stb <= 1'b0;
                  if (wb_req.we)
                     state <= BR_CMD;   // writes get no reply
                  else if (!tx_busy)
                  begin
                     tx_byte <= '{valid: 1'b1, data: wb_rsp.dat[15:8]};
                     state   <= BR_TX_GAP;
                  end
                  else
                     state <= BR_TX_HI;
               end
            BR_TX_HI:
               if (!tx_busy)
               begin
                  tx_byte <= '{valid: 1'b1, data: rd_data[15:8]};
                  state   <= BR_TX_GAP;
               end
            BR_TX_GAP:
               state <= BR_TX_LO;   // tx_busy shows up one cycle after the strobe
            BR_TX_LO:
               if (!tx_busy)
               begin
                  tx_byte <= '{valid: 1'b1, data: rd_data[7:0]};
                  state   <= BR_CMD;
               end
            default: state <= BR_CMD;
         endcase
      end
   end

   always_ff @(posedge clk50)
   begin
      if (state == BR_CMD && rx_byte.valid)
         cmd_adr <= rx_byte.data[3:0];   // bits 6:4 ignored
      if (state == BR_DAT_HI && rx_byte.valid)
         dat_hi <= rx_byte.data;
      if (state == BR_BUS && wb_rsp.ack)
         rd_data <= wb_rsp.dat;
   end

endmodule

//--- ps2_kbd_rx.sv
`timescale 1ns/10ps

module ps2_kbd_rx (
   input  logic                  clk50,
   input  logic                  rst_n,
   input  logic                  ps2_clk,
   input  logic                  ps2_data,
   output caddr_io_pkg::kb_evt_t kb_evt
);

   logic [1:0]  clk_sync;
   logic [1:0]  dat_sync;
   logic        clk_prev;   // edge register
   logic        clk_fall;
   logic [3:0]  bit_cnt;
   logic [9:0]  shift;      // start, data and parity bits
   logic [10:0] frame;
   logic        frame_ok;
   logic        last_bit;

   assign clk_fall = clk_prev && !clk_sync[1];
   assign last_bit = (bit_cnt == 4'd10);

   // frame as it stands once the stop bit is in
   assign frame = {dat_sync[1], shift};

   // start low, odd parity over data and parity bit, stop high
   assign frame_ok = !frame[0] && (^frame[9:1]) && frame[10];

   always_ff @(posedge clk50)
   begin
      if (!rst_n)
      begin
         clk_sync <= 2'b11;
         dat_sync <= 2'b11;
         clk_prev <= 1'b1;
         bit_cnt  <= '0;
         kb_evt   <= '0;
      end
      else
      begin
         clk_sync     <= {clk_sync[0], ps2_clk};
         dat_sync     <= {dat_sync[0], ps2_data};
         clk_prev     <= clk_sync[1];
         kb_evt.valid <= 1'b0;
         if (clk_fall)
         begin
            if (last_bit)
            begin
               bit_cnt <= '0;
               kb_evt  <= '{valid: 1'b1, err: !frame_ok, code: frame[8:1]};
            end
            else
               bit_cnt <= bit_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk50)
   begin
      if (clk_fall && !last_bit)
         shift <= {dat_sync[1], shift[9:1]};
   end

endmodule

//--- spy_uart_rx.sv
`timescale 1ns/10ps

module spy_uart_rx #(
   parameter int CLKS_PER_BIT = 16
) (
   input  logic                    clk50,
   input  logic                    rst_n,
   input  logic                    rxd,
   output caddr_io_pkg::byte_evt_t rx_byte
);

   localparam int CW = $clog2(CLKS_PER_BIT + 1);

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

   rx_state_t     state;
   logic [1:0]    rxd_sync;
   logic [CW-1:0] clk_cnt;
   logic [2:0]    bit_idx;
   logic [7:0]    shift;
   logic          bit_end;

   assign bit_end = (clk_cnt == CW'(CLKS_PER_BIT - 1));

   always_ff @(posedge clk50)
   begin
      if (!rst_n)
      begin
         rxd_sync <= 2'b11;   // line idles high
         state    <= RX_IDLE;
         clk_cnt  <= '0;
         bit_idx  <= '0;
         rx_byte  <= '0;
      end
      else
      begin
         rxd_sync      <= {rxd_sync[0], rxd};
         rx_byte.valid <= 1'b0;
         clk_cnt       <= clk_cnt + 1'b1;
         case (state)
            RX_IDLE:
            begin
               clk_cnt <= '0;
               if (!rxd_sync[1])
                  state <= RX_START;
            end
            RX_START:
               if (clk_cnt == CW'(CLKS_PER_BIT / 2 - 1))
               begin
                  clk_cnt <= '0;
                  bit_idx <= '0;
                  // still low at mid start bit, else it was a glitch
                  state   <= rxd_sync[1] ? RX_IDLE : RX_DATA;
               end
            RX_DATA:
               if (bit_end)
               begin
                  clk_cnt <= '0;
                  bit_idx <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7)
                     state <= RX_STOP;
               end
            RX_STOP:
               if (bit_end)
               begin
                  state <= RX_IDLE;
                  if (rxd_sync[1])   // framing error drops the byte
                     rx_byte <= '{valid: 1'b1, data: shift};
               end
            default: state <= RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk50)
   begin
      if (state == RX_DATA && bit_end)
         shift <= {rxd_sync[1], shift[7:1]};   // lsb first
   end

endmodule

//--- caddr_io_pkg.sv
package caddr_io_pkg;

   // master to slave half of the wishbone bus
   typedef struct packed {
      logic        cyc;
      logic        stb;
      logic        we;
      logic [3:0]  adr;
      logic [15:0] dat;
   } wb_req_t;

   typedef struct packed {
      logic        ack;
      logic [15:0] dat;
   } wb_rsp_t;

   // serial byte strobe, used on both rx and tx side
   typedef struct packed {
      logic       valid;
      logic [7:0] data;
   } byte_evt_t;

   typedef struct packed {
      logic       valid;
      logic       err;   // bad frame, code is don't care
      logic [7:0] code;
   } kb_evt_t;

   localparam logic [3:0] REG_ID      = 4'd0;
   localparam logic [3:0] REG_LED     = 4'd1;
   localparam logic [3:0] REG_KB_STAT = 4'd2;
   localparam logic [3:0] REG_KB_DATA = 4'd3;
   localparam logic [3:0] REG_SCRATCH = 4'd4;

   localparam logic [15:0] ID_VALUE = 16'hCAD2;

   localparam int SPY_WR_BIT = 7;   // command byte, set means write

   localparam int KB_OVF_BIT  = 15;
   localparam int KB_PERR_BIT = 14;

endpackage
